// ==== list.f ====
+incdir+src
src/rv_pkg.sv
src/register_file.sv
src/decoding_stage.sv
src/forwarding_unit.sv
src/execution_stage.sv
src/write_back_stage.sv
src/rv_core.sv
testbench/rv_core_properties.sv
testbench/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module tb_rv_core -f list.f
out=$(./obj_dir/Vtb_rv_core || true)
echo "$out"
echo "$out" | grep -qx "TB PASSED"

// ==== src/decoding_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module decoding_stage (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  stall,
    input  wire                  instr_valid,
    output logic                 instr_ready,
    input  wire [31:0]           instr,
    input  wire rv_pkg::result_t wb_write,
    output rv_pkg::decoded_t     decoded
);

    rv_pkg::opcode_e            opcode;
    rv_pkg::decoded_t           decode_next;
    logic [`RV_REG_ADDR_W-1:0]  rs1_addr;
    logic [`RV_REG_ADDR_W-1:0]  rs2_addr;
    logic [`RV_XLEN-1:0]        rf_data_1;
    logic [`RV_XLEN-1:0]        rf_data_2;
    logic [2:0]                 funct3;
    logic                       funct7_bit5;

    assign funct3      = instr[14:12];
    assign funct7_bit5 = instr[30];

    // Nothing is accepted while the pipeline is frozen
    assign instr_ready = ~stall;

    ////////////////////////////////////////
    // Instruction decode
    ////////////////////////////////////////

    always_comb begin
        case (instr[6:0])
            `RV_OPC_OP:     opcode = rv_pkg::OPC_OP;
            `RV_OPC_OP_IMM: opcode = rv_pkg::OPC_OP_IMM;
            `RV_OPC_LUI:    opcode = rv_pkg::OPC_LUI;
            default:        opcode = rv_pkg::OPC_OTHER;
        endcase
    end

    // Source registers stay x0 where the format has none
    always_comb begin
        rs1_addr = '0;
        rs2_addr = '0;
        if ((opcode == rv_pkg::OPC_OP) || (opcode == rv_pkg::OPC_OP_IMM)) begin
            rs1_addr = instr[19:15];
        end
        if (opcode == rv_pkg::OPC_OP) begin
            rs2_addr = instr[24:20];
        end
    end

    always_comb begin
        decode_next              = '0;
        decode_next.valid        = instr_valid;
        decode_next.rs1          = rs1_addr;
        decode_next.rs2          = rs2_addr;
        decode_next.rd           = instr[11:7];
        decode_next.alu_op       = rv_pkg::ALU_PASS_B;
        case (opcode)
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                decode_next.write_enable = 1'b1;
                // Immediate form uses the I-type field
                if (opcode == rv_pkg::OPC_OP_IMM) begin
                    decode_next.use_imm = 1'b1;
                    decode_next.imm     = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
                end
                case (funct3)
                    3'b000: begin
                        if ((opcode == rv_pkg::OPC_OP) && funct7_bit5) begin
                            decode_next.alu_op = rv_pkg::ALU_SUB;
                        end else begin
                            decode_next.alu_op = rv_pkg::ALU_ADD;
                        end
                    end
                    3'b001: decode_next.alu_op = rv_pkg::ALU_SLL;
                    3'b010: decode_next.alu_op = rv_pkg::ALU_SLT;
                    3'b011: decode_next.alu_op = rv_pkg::ALU_SLTU;
                    3'b100: decode_next.alu_op = rv_pkg::ALU_XOR;
                    3'b101: begin
                        if (funct7_bit5) begin
                            decode_next.alu_op = rv_pkg::ALU_SRA;
                        end else begin
                            decode_next.alu_op = rv_pkg::ALU_SRL;
                        end
                    end
                    3'b110: decode_next.alu_op = rv_pkg::ALU_OR;
                    default: decode_next.alu_op = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OPC_LUI: begin
                decode_next.use_imm      = 1'b1;
                decode_next.imm          = {instr[31:12], 12'b0};
                decode_next.write_enable = 1'b1;
            end
            // Unknown opcode retires without a register write
            default: decode_next.write_enable = 1'b0;
        endcase

        // Write-through for a register retiring in this same cycle
        decode_next.rs1_data = rf_data_1;
        decode_next.rs2_data = rf_data_2;
        if (wb_write.write_enable && (wb_write.rd != '0)) begin
            if (wb_write.rd == rs1_addr) begin
                decode_next.rs1_data = wb_write.data;
            end
            if (wb_write.rd == rs2_addr) begin
                decode_next.rs2_data = wb_write.data;
            end
        end
    end

    register_file u_register_file (
        .clk          (clk),
        .write_enable (wb_write.write_enable),
        .write_addr   (wb_write.rd),
        .write_data   (wb_write.data),
        .read_addr_1  (rs1_addr),
        .read_addr_2  (rs2_addr),
        .read_data_1  (rf_data_1),
        .read_data_2  (rf_data_2)
    );

    ////////////////////////////////////////
    // Decode register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            decoded.valid <= 1'b0;
        end else if (!stall) begin
            decoded <= decode_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/execution_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module execution_stage (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    stall,
    input  wire rv_pkg::decoded_t  decoded,
    input  wire [`RV_XLEN-1:0]     rs1_value,
    input  wire [`RV_XLEN-1:0]     rs2_value,
    output rv_pkg::result_t        ex_result,
    output logic                   ex_valid
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic [`RV_XLEN-1:0] operand_b;
    logic [SHAMT_W-1:0]  shamt;
    logic [`RV_XLEN-1:0] alu_out;

    assign operand_b = decoded.use_imm ? decoded.imm : rs2_value;
    assign shamt     = operand_b[SHAMT_W-1:0];

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (decoded.alu_op)
            rv_pkg::ALU_ADD:    alu_out = rs1_value + operand_b;
            rv_pkg::ALU_SUB:    alu_out = rs1_value - operand_b;
            rv_pkg::ALU_SLL:    alu_out = rs1_value << shamt;
            rv_pkg::ALU_SLT: begin
                alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(rs1_value) < $signed(operand_b)};
            end
            rv_pkg::ALU_SLTU: begin
                alu_out = {{(`RV_XLEN-1){1'b0}}, rs1_value < operand_b};
            end
            rv_pkg::ALU_XOR:    alu_out = rs1_value ^ operand_b;
            rv_pkg::ALU_SRL:    alu_out = rs1_value >> shamt;
            rv_pkg::ALU_SRA:    alu_out = $unsigned($signed(rs1_value) >>> shamt);
            rv_pkg::ALU_OR:     alu_out = rs1_value | operand_b;
            rv_pkg::ALU_AND:    alu_out = rs1_value & operand_b;
            rv_pkg::ALU_PASS_B: alu_out = operand_b;
            default:            alu_out = '0;
        endcase
    end

    ////////////////////////////////////////
    // Execute register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (!stall) begin
            ex_valid <= decoded.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_result.rd           <= decoded.rd;
            ex_result.write_enable <= decoded.write_enable;
            // Non-writing instructions carry zero data
            ex_result.data         <= decoded.write_enable ? alu_out : '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/forwarding_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module forwarding_unit (
    input  wire rv_pkg::decoded_t  decoded,
    input  wire rv_pkg::result_t   ex_result,
    input  wire                    ex_valid,
    input  wire rv_pkg::result_t   wb_result,
    input  wire                    wb_valid,
    output logic [`RV_XLEN-1:0]    rs1_value,
    output logic [`RV_XLEN-1:0]    rs2_value
);

    // The execute register beats write back, which beats the register file
    function automatic logic [`RV_XLEN-1:0] pick_value(
        input logic [`RV_REG_ADDR_W-1:0] src,
        input logic [`RV_XLEN-1:0]       file_value
    );
        logic ex_hit;
        logic wb_hit;
        ex_hit = ex_valid && ex_result.write_enable && (ex_result.rd == src);
        wb_hit = wb_valid && wb_result.write_enable && (wb_result.rd == src);
        if (src == '0) begin
            return '0;
        end else if (ex_hit) begin
            return ex_result.data;
        end else if (wb_hit) begin
            return wb_result.data;
        end
        return file_value;
    endfunction

    always_comb begin
        rs1_value = pick_value(decoded.rs1, decoded.rs1_data);
        rs2_value = pick_value(decoded.rs2, decoded.rs2_data);
    end

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module register_file (
    input  wire                        clk,
    input  wire logic                  write_enable,
    input  wire [`RV_REG_ADDR_W-1:0]   write_addr,
    input  wire [`RV_XLEN-1:0]         write_data,
    input  wire [`RV_REG_ADDR_W-1:0]   read_addr_1,
    input  wire [`RV_REG_ADDR_W-1:0]   read_addr_2,
    output logic [`RV_XLEN-1:0]        read_data_1,
    output logic [`RV_XLEN-1:0]        read_data_2
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    // x0 is never stored
    always_ff @(posedge clk) begin
        if (write_enable && (write_addr != '0)) begin
            regs[write_addr] <= write_data;
        end
    end

    // Asynchronous read ports, x0 hardwired to zero
    always_comb begin
        if (read_addr_1 == '0) begin
            read_data_1 = '0;
        end else begin
            read_data_1 = regs[read_addr_1];
        end
        if (read_addr_2 == '0) begin
            read_data_2 = '0;
        end else begin
            read_data_2 = regs[read_addr_2];
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath and register file sizes
`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_NUM_REGS    32

// Major opcode field, instr[6:0]
`define RV_OPC_W       7
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_LUI     7'b0110111

`endif

// ==== src/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_core (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   instr_valid,
    output logic                  instr_ready,
    input  wire [31:0]            instr,
    output logic                  result_valid,
    input  wire                   result_ready,
    output rv_pkg::result_t       result
);

    // Global back-pressure stall from write back
    logic                 stall;

    // Decode register to forwarding and execute
    rv_pkg::decoded_t     decoded;

    // Forwarded operands
    logic [`RV_XLEN-1:0]  rs1_value;
    logic [`RV_XLEN-1:0]  rs2_value;

    // Execute register to write back and forwarding
    rv_pkg::result_t      ex_result;
    logic                 ex_valid;

    // Register file write port
    rv_pkg::result_t      wb_write;

    decoding_stage u_decoding_stage (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .wb_write     (wb_write),
        .decoded      (decoded)
    );

    forwarding_unit u_forwarding_unit (
        .decoded      (decoded),
        .ex_result    (ex_result),
        .ex_valid     (ex_valid),
        .wb_result    (result),
        .wb_valid     (result_valid),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value)
    );

    execution_stage u_execution_stage (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .decoded      (decoded),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .ex_result    (ex_result),
        .ex_valid     (ex_valid)
    );

    write_back_stage u_write_back_stage (
        .clk          (clk),
        .rst          (rst),
        .ex_result    (ex_result),
        .ex_valid     (ex_valid),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result),
        .stall        (stall),
        .wb_write     (wb_write)
    );

endmodule

`default_nettype wire

// ==== src/rv_pkg.sv ====
`default_nettype none
`include "rv_consts.svh"

package rv_pkg;

    // Major opcodes the core understands
    typedef enum logic [`RV_OPC_W-1:0] {
        OPC_OP     = `RV_OPC_OP,
        OPC_OP_IMM = `RV_OPC_OP_IMM,
        OPC_LUI    = `RV_OPC_LUI,
        OPC_OTHER  = 7'h00
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // Decode register contents, consumed by forwarding and execute
    typedef struct packed {
        logic                        valid;
        logic [`RV_REG_ADDR_W-1:0]   rs1;
        logic [`RV_REG_ADDR_W-1:0]   rs2;
        logic [`RV_REG_ADDR_W-1:0]   rd;
        logic [`RV_XLEN-1:0]         rs1_data;
        logic [`RV_XLEN-1:0]         rs2_data;
        logic [`RV_XLEN-1:0]         imm;
        alu_op_e                     alu_op;
        logic                        use_imm;
        logic                        write_enable;
    } decoded_t;

    // One retired instruction
    typedef struct packed {
        logic [`RV_REG_ADDR_W-1:0]   rd;
        logic [`RV_XLEN-1:0]         data;
        logic                        write_enable;
    } result_t;

endpackage

`default_nettype wire

// ==== src/write_back_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_back_stage (
    input  wire                   clk,
    input  wire                   rst,
    input  wire rv_pkg::result_t  ex_result,
    input  wire                   ex_valid,
    output logic                  result_valid,
    input  wire                   result_ready,
    output rv_pkg::result_t       result,
    output logic                  stall,
    output rv_pkg::result_t       wb_write
);

    // Output held by the consumer freezes the whole pipeline
    assign stall = result_valid & ~result_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else if (!stall) begin
            result_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            result <= ex_result;
        end
    end

    ////////////////////////////////////////
    // Register file write on handshake
    ////////////////////////////////////////

    always_comb begin
        wb_write              = result;
        wb_write.write_enable = result.write_enable & result_valid & result_ready;
    end

endmodule

`default_nettype wire

// ==== testbench/rv_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties (
    input wire                  clk,
    input wire                  rst,
    input wire                  instr_ready,
    input wire                  result_valid,
    input wire                  result_ready,
    input wire rv_pkg::result_t result
);

    // A held result keeps its value until the consumer takes it
    assert property (@(posedge clk) disable iff (rst)
        (result_valid && !result_ready) |=> (result_valid && $stable(result)))
        else $error("result changed while held by back-pressure");

    // Input is refused exactly while a result is held back
    assert property (@(posedge clk) disable iff (rst)
        instr_ready == !(result_valid && !result_ready))
        else $error("instr_ready is not the inverse of the back-pressure stall");

    assert property (@(posedge clk) rst |=> !result_valid)
        else $error("result_valid high in the cycle after reset");

endmodule

bind rv_core rv_core_properties u_properties (
    .clk          (clk),
    .rst          (rst),
    .instr_ready  (instr_ready),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result)
);

`default_nettype wire

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module tb_rv_core;

    localparam int CLK_PERIOD = 40;
    // Upper bound on the instructions issued by all tests together
    localparam int NUM_INSTR  = 110;

    logic                 clk;
    logic                 rst;
    logic                 instr_valid;
    logic                 instr_ready;
    logic [31:0]          instr;
    logic                 result_valid;
    logic                 result_ready;
    rv_pkg::result_t      result;

    integer               seed;
    integer               errors;
    integer               checks;
    logic                 bp_enable;
    integer               bp_hold;
    logic [`RV_XLEN-1:0]  model_regs [`RV_NUM_REGS];
    rv_pkg::result_t      expected_q [$];

    rv_core UUT (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic rv_pkg::result_t model_execute(input logic [31:0] word);
        rv_pkg::result_t res;
        logic [31:0]     a;
        logic [31:0]     b;
        logic            is_reg;
        res    = '0;
        res.rd = word[11:7];
        is_reg = (word[6:0] == `RV_OPC_OP);
        a      = model_regs[word[19:15]];
        b      = is_reg ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        if (word[6:0] == `RV_OPC_LUI) begin
            res.data         = {word[31:12], 12'b0};
            res.write_enable = 1'b1;
        end else if (is_reg || (word[6:0] == `RV_OPC_OP_IMM)) begin
            res.write_enable = 1'b1;
            case (word[14:12])
                // SUB only exists in the register form
                3'd0: res.data = (is_reg && word[30]) ? a - b : a + b;
                3'd1: res.data = a << b[4:0];
                3'd2: res.data = {31'b0, $signed(a) < $signed(b)};
                3'd3: res.data = {31'b0, a < b};
                3'd4: res.data = a ^ b;
                3'd5: begin
                    if (word[30]) begin
                        res.data = $signed(a) >>> b[4:0];
                    end else begin
                        res.data = a >> b[4:0];
                    end
                end
                3'd6: res.data = a | b;
                default: res.data = a & b;
            endcase
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    // Called on a falling edge and returns on the falling edge after acceptance
    task automatic issue(input logic [31:0] word);
        rv_pkg::result_t exp;
        instr_valid = 1'b1;
        instr       = word;
        #1;
        while (!instr_ready) begin
            @(negedge clk);
            #1;
        end
        exp = model_execute(word);
        if (exp.write_enable && (exp.rd != '0)) begin
            model_regs[exp.rd] = exp.data;
        end
        expected_q.push_back(exp);
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    // Op index 0..7 is funct3 while 8 selects SRA/SRAI and 9 selects SUB
    task automatic issue_alu(input int k, input logic imm_form, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2);
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] rnd;
        logic [11:0] imm;
        alt = (k >= 8);
        f3  = (k == 8) ? 3'd5 : ((k == 9) ? 3'd0 : 3'(k));
        rnd = $random(seed);
        imm = rnd[11:0];
        if ((f3 == 3'd1) || (f3 == 3'd5)) begin
            imm = {1'b0, alt, 5'b0, rnd[4:0]};
        end
        if (imm_form) begin
            issue({imm, rs1, f3, rd, `RV_OPC_OP_IMM});
        end else begin
            issue({1'b0, alt, 5'b0, rs2, rs1, f3, rd, `RV_OPC_OP});
        end
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic confirm_reset_state();
        #1;
        check_value("instr_ready", 64'(instr_ready), 64'd1);
        check_value("result_valid", 64'(result_valid), 64'd0);
        @(negedge clk);
    endtask

    task automatic exercise_all_ops();
        logic [31:0] rnd;
        for (int r = 1; r <= 8; r++) begin
            rnd = $random(seed);
            issue({rnd[31:12], 5'(r), `RV_OPC_LUI});
            rnd = $random(seed);
            issue({rnd[11:0], 5'(r), 3'd0, 5'(r), `RV_OPC_OP_IMM});
        end
        for (int k = 0; k < 10; k++) begin
            issue_alu(k, 1'b0, 5'(9 + k), 5'(1 + {$random(seed)} % 8),
                      5'(1 + {$random(seed)} % 8));
        end
        for (int k = 0; k < 9; k++) begin
            issue_alu(k, 1'b1, 5'(19 + k), 5'(1 + {$random(seed)} % 8), 5'd0);
        end
    endtask

    // Each op reads the results of the two ops just before it
    task automatic chain_dependent_ops();
        for (int i = 0; i < 22; i++) begin
            issue_alu({$random(seed)} % 10, 1'b0, 5'(1 + i % 3), 5'(1 + (i + 2) % 3),
                      5'(1 + (i + 1) % 3));
        end
    endtask

    task automatic stream_under_backpressure();
        bp_enable = 1'b1;
        for (int i = 0; i < 30; i++) begin
            issue_alu({$random(seed)} % 10, 1'($random(seed)), 5'(1 + {$random(seed)} % 27),
                      5'(1 + {$random(seed)} % 27), 5'(1 + {$random(seed)} % 27));
        end
        wait_drain();
        bp_enable = 1'b0;
    endtask

    task automatic probe_x0_and_unsupported();
        issue({12'h123, 5'd0, 3'd0, 5'd0, `RV_OPC_OP_IMM});
        issue({20'habcde, 5'd0, `RV_OPC_LUI});
        issue({7'd0, 5'd0, 5'd0, 3'd0, 5'd5, `RV_OPC_OP});
        issue({12'h0f0, 5'd0, 3'd6, 5'd6, `RV_OPC_OP_IMM});
        // Load and JAL encodings
        issue({12'h004, 5'd2, 3'd2, 5'd7, 7'b0000011});
        issue({20'h12345, 5'd8, 7'b1101111});
        issue({7'd0, 5'd8, 5'd7, 3'd0, 5'd9, `RV_OPC_OP});
        wait_drain();
    endtask

    ////////////////////////////////////////
    // Result collector and back-pressure
    ////////////////////////////////////////

    initial begin
        rv_pkg::result_t exp;
        forever begin
            @(negedge clk);
            #1;
            if (!rst && result_valid && result_ready) begin
                if (expected_q.size() == 0) begin
                    errors = errors + 1;
                    $display("Result retired with no instruction outstanding");
                end else begin
                    exp = expected_q.pop_front();
                    check_value("result.rd", 64'(result.rd), 64'(exp.rd));
                    check_value("result.data", 64'(result.data), 64'(exp.data));
                    check_value("result.write_enable", 64'(result.write_enable),
                                64'(exp.write_enable));
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!bp_enable) begin
            result_ready = 1'b1;
        end else if (bp_hold > 0) begin
            result_ready = 1'b0;
            bp_hold      = bp_hold - 1;
        end else if (($random(seed) & 3) == 0) begin
            result_ready = 1'b0;
            bp_hold      = $random(seed) & 3;
        end else begin
            result_ready = 1'b1;
        end
    end

    initial begin
        #(CLK_PERIOD * NUM_INSTR * 8 + 50 * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        seed         = 3;
        errors       = 0;
        checks       = 0;
        clk          = 1'b0;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        result_ready = 1'b1;
        bp_enable    = 1'b0;
        bp_hold      = 0;
        for (int r = 0; r < `RV_NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        confirm_reset_state();
        exercise_all_ops();
        chain_dependent_ops();
        stream_under_backpressure();
        probe_x0_and_unsupported();
        wait_drain();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
